// ==== logic/pipe_pkg.sv ====
// PC is only pc_w bits wide, so both memories hold 2**(pc_w-2) words
package pipe_pkg;

	localparam int xlen   = 32;
	localparam int reg_aw = 5;
	localparam int pc_w   = 9;

	// operand source selects for the execute stage
	localparam logic [1:0] fwd_none = 2'd0;
	localparam logic [1:0] fwd_mem  = 2'd1;
	localparam logic [1:0] fwd_wb   = 2'd2;

endpackage

// ==== logic/isa_pkg.sv ====
// covers only the rv32i subset used by the core: no shifts, no byte or halfword access, no lui/auipc
package isa_pkg;

	// major opcodes
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;

	// funct fields that change the ALU operation
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [6:0] f7_sub = 7'b0100000;

	// ALU control codes
	localparam logic [3:0] alu_and = 4'd0;
	localparam logic [3:0] alu_or  = 4'd1;
	localparam logic [3:0] alu_add = 4'd2;
	localparam logic [3:0] alu_sub = 4'd6;
	localparam logic [3:0] alu_slt = 4'd7;

	// one instruction word, register view and store view
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} inst_u;

endpackage

// ==== logic/reg_file.sv ====
// two read ports see a same-cycle write; x0 is never written and reads zero
`timescale 1ns/1ps

module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        we,
	input  logic [pipe_pkg::reg_aw-1:0] waddr,
	input  logic [pipe_pkg::xlen-1:0]   wdata,
	input  logic [pipe_pkg::reg_aw-1:0] raddr1,
	input  logic [pipe_pkg::reg_aw-1:0] raddr2,
	output logic [pipe_pkg::xlen-1:0]   rdata1,
	output logic [pipe_pkg::xlen-1:0]   rdata2
);
	logic [pipe_pkg::xlen-1:0] regs [2**pipe_pkg::reg_aw];

	function automatic logic [pipe_pkg::xlen-1:0] read_port(
		input logic [pipe_pkg::reg_aw-1:0] addr
	);
		if (addr == '0)
			read_port = '0;
		else if (we && addr == waddr)
			read_port = wdata;
		else
			read_port = regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**pipe_pkg::reg_aw; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = read_port(raddr1);
	assign rdata2 = read_port(raddr2);

endmodule

// ==== logic/fetch_stage.sv ====
// branch redirect beats a decode jump; a flushed IF/ID slot holds the all-zero word as a no-op
`timescale 1ns/1ps

module fetch_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      freeze,
	input  logic                      pc_hold,
	input  logic                      if_flush,
	input  logic                      jump,
	input  logic [pipe_pkg::pc_w-1:0] jump_target,
	input  logic                      br_taken,
	input  logic [pipe_pkg::pc_w-1:0] br_target,
	input  logic [pipe_pkg::xlen-1:0] imem_rdata,
	output logic [pipe_pkg::pc_w-3:0] imem_addr,
	output isa_pkg::inst_u            id_inst,
	output logic [pipe_pkg::pc_w-1:0] id_pc,
	output logic [pipe_pkg::pc_w-1:0] id_pc4
);
	logic [pipe_pkg::pc_w-1:0] pc;
	logic [pipe_pkg::pc_w-1:0] pc4;
	logic [pipe_pkg::pc_w-1:0] next_pc;

	assign pc4       = pc + pipe_pkg::pc_w'(4);
	assign next_pc   = br_taken ? br_target : (jump ? jump_target : pc4);
	assign imem_addr = pc[pipe_pkg::pc_w-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!freeze && !pc_hold) begin
			pc <= next_pc;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{id_inst, id_pc, id_pc4} <= '0;
		end else if (!freeze) begin
			if (if_flush) begin
				{id_inst, id_pc, id_pc4} <= '0;
			end else if (!pc_hold) begin
				id_inst <= imem_rdata;
				id_pc   <= pc;
				id_pc4  <= pc4;
			end
		end
	end

endmodule

// ==== logic/decode_ctrl.sv ====
// unknown opcodes decode to no controls; the branch target leaves on jump_target too
`timescale 1ns/1ps

module decode_ctrl (
	input  isa_pkg::inst_u              id_inst,
	input  logic [pipe_pkg::pc_w-1:0]   id_pc,
	input  logic [pipe_pkg::xlen-1:0]   jalr_base,
	output logic [pipe_pkg::reg_aw-1:0] rs1,
	output logic [pipe_pkg::reg_aw-1:0] rs2,
	output logic [pipe_pkg::reg_aw-1:0] rd,
	output logic                        reg_write,
	output logic                        mem_read,
	output logic                        mem_write,
	output logic                        mem_to_reg,
	output logic                        alu_src,
	output logic [3:0]                  alu_ctrl,
	output logic                        is_branch,
	output logic                        is_bne,
	output logic                        jump,
	output logic                        is_jalr,
	output logic                        link,
	output logic [pipe_pkg::xlen-1:0]   imm,
	output logic [pipe_pkg::pc_w-1:0]   jump_target
);
	logic [pipe_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j;
	logic [pipe_pkg::xlen-1:0] jalr_sum;

	function automatic logic [3:0] alu_op(input logic [2:0] f3, input logic sub);
		case (f3)
			isa_pkg::f3_slt: alu_op = isa_pkg::alu_slt;
			isa_pkg::f3_or:  alu_op = isa_pkg::alu_or;
			isa_pkg::f3_and: alu_op = isa_pkg::alu_and;
			default:         alu_op = sub ? isa_pkg::alu_sub : isa_pkg::alu_add;
		endcase
	endfunction

	assign rs1 = id_inst.r.rs1;
	assign rs2 = id_inst.r.rs2;
	assign rd  = id_inst.r.rd;

	assign imm_i = {{20{id_inst[31]}}, id_inst.r.funct7, id_inst.r.rs2};
	assign imm_s = {{20{id_inst[31]}}, id_inst.s.imm_hi, id_inst.s.imm_lo};
	assign imm_b = {{20{id_inst[31]}}, id_inst.s.imm_lo[0], id_inst.s.imm_hi[5:0],
		id_inst.s.imm_lo[4:1], 1'b0};
	assign imm_j = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};

	always_comb begin
		{reg_write, mem_read, mem_write, mem_to_reg, alu_src} = '0;
		{is_branch, is_bne, jump, is_jalr, link} = '0;
		alu_ctrl = isa_pkg::alu_add;
		imm      = imm_i;
		case (id_inst.r.opcode)
			isa_pkg::op_rtype: begin
				reg_write = 1'b1;
				alu_ctrl  = alu_op(id_inst.r.funct3, id_inst.r.funct7 == isa_pkg::f7_sub);
			end
			isa_pkg::op_itype: begin
				{reg_write, alu_src} = 2'b11;
				alu_ctrl = alu_op(id_inst.r.funct3, 1'b0);
			end
			isa_pkg::op_load: {reg_write, mem_read, mem_to_reg, alu_src} = 4'b1111;
			isa_pkg::op_store: begin
				{mem_write, alu_src} = 2'b11;
				imm = imm_s;
			end
			isa_pkg::op_branch: begin
				is_branch = 1'b1;
				is_bne    = id_inst.r.funct3 == isa_pkg::f3_bne;
				alu_ctrl  = isa_pkg::alu_sub;
				imm       = imm_b;
			end
			isa_pkg::op_jal: begin
				{reg_write, alu_src, jump, link} = 4'b1111;
				imm = imm_j;
			end
			isa_pkg::op_jalr: {reg_write, alu_src, jump, is_jalr, link} = 5'b11111;
			default: ;
		endcase
	end

	// jalr clears bit 0 of the sum
	assign jalr_sum    = jalr_base + imm;
	assign jump_target = is_jalr ? {jalr_sum[pipe_pkg::pc_w-1:1], 1'b0}
	                             : id_pc + imm[pipe_pkg::pc_w-1:0];

endmodule

// ==== logic/hazard_forward.sv ====
// assumes the register file writes through, so writeback never needs a forward into decode
`timescale 1ns/1ps

module hazard_forward (
	input  logic [pipe_pkg::reg_aw-1:0] rs1,
	input  logic [pipe_pkg::reg_aw-1:0] rs2,
	input  logic                        uses_rs2,
	input  logic                        is_jalr,
	input  logic                        jump,
	input  logic                        br_taken,
	input  logic [pipe_pkg::reg_aw-1:0] ex_rs1,
	input  logic [pipe_pkg::reg_aw-1:0] ex_rs2,
	input  logic [pipe_pkg::reg_aw-1:0] ex_rd,
	input  logic                        ex_reg_write,
	input  logic                        ex_mem_read,
	input  logic [pipe_pkg::reg_aw-1:0] mem_rd,
	input  logic                        mem_reg_write,
	input  logic                        mem_mem_read,
	input  logic [pipe_pkg::reg_aw-1:0] wb_rd,
	input  logic                        wb_reg_write,
	output logic                        pc_hold,
	output logic                        bubble,
	output logic                        if_flush,
	output logic [1:0]                  fwd_a,
	output logic [1:0]                  fwd_b
);
	logic load_use;
	logic jalr_wait;
	logic stall;

	// newest producer wins; a load still in memory has no data yet
	function automatic logic [1:0] pick(input logic [pipe_pkg::reg_aw-1:0] src);
		if (src == '0)
			pick = pipe_pkg::fwd_none;
		else if (mem_reg_write && !mem_mem_read && mem_rd == src)
			pick = pipe_pkg::fwd_mem;
		else if (wb_reg_write && wb_rd == src)
			pick = pipe_pkg::fwd_wb;
		else
			pick = pipe_pkg::fwd_none;
	endfunction

	assign load_use = ex_mem_read && ex_rd != '0 &&
		(ex_rd == rs1 || (uses_rs2 && ex_rd == rs2));
	assign jalr_wait = is_jalr && rs1 != '0 &&
		((ex_reg_write && ex_rd == rs1) || (mem_reg_write && mem_rd == rs1));
	assign stall = load_use | jalr_wait;

	// a taken branch kills whatever sits in decode, stalled or not
	assign pc_hold  = stall & ~br_taken;
	assign bubble   = stall | br_taken;
	assign if_flush = br_taken | (jump & ~stall);

	assign fwd_a = pick(ex_rs1);
	assign fwd_b = pick(ex_rs2);

endmodule

// ==== logic/execute_stage.sv ====
// BEQ and BNE resolve here from the ALU zero flag; a bubble clears only the side-effect controls
`timescale 1ns/1ps

module execute_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        freeze,
	input  logic                        bubble,
	input  logic [pipe_pkg::reg_aw-1:0] id_rs1,
	input  logic [pipe_pkg::reg_aw-1:0] id_rs2,
	input  logic [pipe_pkg::reg_aw-1:0] id_rd,
	input  logic                        id_reg_write,
	input  logic                        id_mem_read,
	input  logic                        id_mem_write,
	input  logic                        id_mem_to_reg,
	input  logic                        id_alu_src,
	input  logic [3:0]                  id_alu_ctrl,
	input  logic                        id_is_branch,
	input  logic                        id_is_bne,
	input  logic                        id_link,
	input  logic [pipe_pkg::xlen-1:0]   id_imm,
	input  logic [pipe_pkg::pc_w-1:0]   id_target,
	input  logic [pipe_pkg::pc_w-1:0]   id_pc4,
	input  logic [pipe_pkg::xlen-1:0]   id_rdata1,
	input  logic [pipe_pkg::xlen-1:0]   id_rdata2,
	input  logic [1:0]                  fwd_a,
	input  logic [1:0]                  fwd_b,
	input  logic [pipe_pkg::xlen-1:0]   wb_data,
	output logic [pipe_pkg::reg_aw-1:0] ex_rs1,
	output logic [pipe_pkg::reg_aw-1:0] ex_rs2,
	output logic [pipe_pkg::reg_aw-1:0] ex_rd,
	output logic                        ex_reg_write,
	output logic                        ex_mem_read,
	output logic                        br_taken,
	output logic [pipe_pkg::pc_w-1:0]   br_target,
	output logic [pipe_pkg::reg_aw-1:0] mem_rd,
	output logic                        mem_reg_write,
	output logic                        mem_mem_read,
	output logic                        mem_mem_write,
	output logic                        mem_to_reg,
	output logic                        mem_link,
	output logic [pipe_pkg::xlen-1:0]   mem_alu,
	output logic [pipe_pkg::xlen-1:0]   mem_store,
	output logic [pipe_pkg::pc_w-1:0]   mem_pc4
);
	logic ex_mem_write, ex_mem_to_reg, ex_alu_src, ex_is_branch, ex_is_bne, ex_link;
	logic [3:0] ex_alu_ctrl;
	logic [pipe_pkg::xlen-1:0] ex_imm, ex_rdata1, ex_rdata2;
	logic [pipe_pkg::pc_w-1:0] ex_target, ex_pc4;
	logic [pipe_pkg::xlen-1:0] mem_fwd, op_a, op_b_reg, op_b, alu_y;

	function automatic logic [pipe_pkg::xlen-1:0] fwd_mux(input logic [1:0] sel,
		input logic [pipe_pkg::xlen-1:0] reg_val, mem_val, wb_val);
		case (sel)
			pipe_pkg::fwd_mem: fwd_mux = mem_val;
			pipe_pkg::fwd_wb:  fwd_mux = wb_val;
			default:           fwd_mux = reg_val;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// ID/EX
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_is_branch, ex_link} <= '0;
			{ex_rs1, ex_rs2, ex_rd, ex_alu_src, ex_alu_ctrl, ex_is_bne} <= '0;
			{ex_imm, ex_target, ex_pc4, ex_rdata1, ex_rdata2} <= '0;
		end else if (!freeze) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_is_branch, ex_link} <=
				bubble ? '0 : {id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg,
				id_is_branch, id_link};
			{ex_rs1, ex_rs2, ex_rd, ex_alu_src, ex_alu_ctrl, ex_is_bne} <=
				{id_rs1, id_rs2, id_rd, id_alu_src, id_alu_ctrl, id_is_bne};
			{ex_imm, ex_target, ex_pc4, ex_rdata1, ex_rdata2} <=
				{id_imm, id_target, id_pc4, id_rdata1, id_rdata2};
		end
	end

	// ----------------------------------------------------------------------
	// a link instruction in memory carries its value in pc4, not in the ALU field
	assign mem_fwd  = mem_link ? {{(pipe_pkg::xlen-pipe_pkg::pc_w){1'b0}}, mem_pc4} : mem_alu;
	assign op_a     = fwd_mux(fwd_a, ex_rdata1, mem_fwd, wb_data);
	assign op_b_reg = fwd_mux(fwd_b, ex_rdata2, mem_fwd, wb_data);
	assign op_b     = ex_alu_src ? ex_imm : op_b_reg;

	always_comb begin
		case (ex_alu_ctrl)
			isa_pkg::alu_sub: alu_y = op_a - op_b;
			isa_pkg::alu_and: alu_y = op_a & op_b;
			isa_pkg::alu_or:  alu_y = op_a | op_b;
			isa_pkg::alu_slt: alu_y = {{(pipe_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default:          alu_y = op_a + op_b;
		endcase
	end

	assign br_taken  = ex_is_branch & (ex_is_bne ^ (alu_y == '0));
	assign br_target = ex_target;

	// ----------------------------------------------------------------------
	// EX/MEM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{mem_reg_write, mem_mem_read, mem_mem_write, mem_to_reg, mem_link} <= '0;
			{mem_rd, mem_alu, mem_store, mem_pc4} <= '0;
		end else if (!freeze) begin
			{mem_reg_write, mem_mem_read, mem_mem_write, mem_to_reg, mem_link} <=
				{ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_link};
			{mem_rd, mem_alu, mem_store, mem_pc4} <= {ex_rd, alu_y, op_b_reg, ex_pc4};
		end
	end

endmodule

// ==== logic/mem_wb_stage.sv ====
// data port is driven straight from EX/MEM and holds while frozen; addresses are word aligned
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        freeze,
	input  logic [pipe_pkg::reg_aw-1:0] mem_rd,
	input  logic                        mem_reg_write,
	input  logic                        mem_mem_read,
	input  logic                        mem_mem_write,
	input  logic                        mem_to_reg,
	input  logic                        mem_link,
	input  logic [pipe_pkg::xlen-1:0]   mem_alu,
	input  logic [pipe_pkg::xlen-1:0]   mem_store,
	input  logic [pipe_pkg::pc_w-1:0]   mem_pc4,
	input  logic [pipe_pkg::xlen-1:0]   dmem_rdata,
	output logic                        dmem_read,
	output logic                        dmem_write,
	output logic [pipe_pkg::xlen-3:0]   dmem_addr,
	output logic [pipe_pkg::xlen-1:0]   dmem_wdata,
	output logic                        wb_we,
	output logic [pipe_pkg::reg_aw-1:0] wb_rd,
	output logic [pipe_pkg::xlen-1:0]   wb_data
);
	logic wb_link, wb_to_reg;
	logic [pipe_pkg::xlen-1:0] wb_alu, wb_load;
	logic [pipe_pkg::pc_w-1:0] wb_pc4;

	assign dmem_read  = mem_mem_read;
	assign dmem_write = mem_mem_write;
	assign dmem_addr  = mem_alu[pipe_pkg::xlen-1:2];
	assign dmem_wdata = mem_store;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{wb_we, wb_link, wb_to_reg} <= '0;
			{wb_rd, wb_alu, wb_load, wb_pc4} <= '0;
		end else if (!freeze) begin
			{wb_we, wb_link, wb_to_reg} <= {mem_reg_write, mem_link, mem_to_reg};
			{wb_rd, wb_alu, wb_load, wb_pc4} <= {mem_rd, mem_alu, dmem_rdata, mem_pc4};
		end
	end

	assign wb_data = wb_link   ? {{(pipe_pkg::xlen-pipe_pkg::pc_w){1'b0}}, wb_pc4}
	               : wb_to_reg ? wb_load
	               : wb_alu;

endmodule

// ==== logic/riscv_core.sv ====
// five-stage core; both memory ports answer in the same cycle and either stall freezes the pipe
`timescale 1ns/1ps

module riscv_core (
	input  logic                         clk,
	input  logic                         rst_n,
	output logic [pipe_pkg::pc_w-3:0]    imem_addr,
	input  logic [pipe_pkg::xlen-1:0]    imem_rdata,
	input  logic                         imem_stall,
	output logic                         dmem_read,
	output logic                         dmem_write,
	output logic [pipe_pkg::xlen-3:0]    dmem_addr,
	output logic [pipe_pkg::xlen-1:0]    dmem_wdata,
	input  logic [pipe_pkg::xlen-1:0]    dmem_rdata,
	input  logic                         dmem_stall
);
	logic freeze;
	logic pc_hold;
	logic bubble;
	logic if_flush;
	logic uses_rs2;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;

	isa_pkg::inst_u id_inst;
	logic [pipe_pkg::pc_w-1:0] id_pc, id_pc4, jump_target, br_target, mem_pc4;
	logic [pipe_pkg::reg_aw-1:0] rs1, rs2, rd, ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
	logic [pipe_pkg::xlen-1:0] imm, rdata1, rdata2, mem_alu, mem_store, wb_data;
	logic [3:0] alu_ctrl;

	logic reg_write, mem_read, mem_write, mem_to_reg, alu_src;
	logic is_branch, is_bne, jump, is_jalr, link;
	logic ex_reg_write, ex_mem_read, br_taken;
	logic mem_reg_write, mem_mem_read, mem_mem_write, mem_to_reg_q, mem_link;
	logic wb_we;

	assign freeze = imem_stall | dmem_stall;
	// stores read rs2 as data even though the ALU takes the immediate
	assign uses_rs2 = ~alu_src | mem_write;

	// ----------------------------------------------------------------------
	fetch_stage u_fetch (
		.clk(clk), .rst_n(rst_n), .freeze(freeze), .pc_hold(pc_hold), .if_flush(if_flush),
		.jump(jump), .jump_target(jump_target), .br_taken(br_taken), .br_target(br_target),
		.imem_rdata(imem_rdata), .imem_addr(imem_addr),
		.id_inst(id_inst), .id_pc(id_pc), .id_pc4(id_pc4)
	);

	decode_ctrl u_decode (
		.id_inst(id_inst), .id_pc(id_pc), .jalr_base(rdata1),
		.rs1(rs1), .rs2(rs2), .rd(rd), .reg_write(reg_write), .mem_read(mem_read),
		.mem_write(mem_write), .mem_to_reg(mem_to_reg), .alu_src(alu_src), .alu_ctrl(alu_ctrl),
		.is_branch(is_branch), .is_bne(is_bne), .jump(jump), .is_jalr(is_jalr), .link(link),
		.imm(imm), .jump_target(jump_target)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .we(wb_we), .waddr(wb_rd), .wdata(wb_data),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2)
	);

	hazard_forward u_hazard (
		.rs1(rs1), .rs2(rs2), .uses_rs2(uses_rs2), .is_jalr(is_jalr), .jump(jump),
		.br_taken(br_taken), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read), .mem_rd(mem_rd),
		.mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read), .wb_rd(wb_rd),
		.wb_reg_write(wb_we), .pc_hold(pc_hold), .bubble(bubble), .if_flush(if_flush),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	// ----------------------------------------------------------------------
	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n), .freeze(freeze), .bubble(bubble),
		.id_rs1(rs1), .id_rs2(rs2), .id_rd(rd), .id_reg_write(reg_write),
		.id_mem_read(mem_read), .id_mem_write(mem_write), .id_mem_to_reg(mem_to_reg),
		.id_alu_src(alu_src), .id_alu_ctrl(alu_ctrl), .id_is_branch(is_branch),
		.id_is_bne(is_bne), .id_link(link), .id_imm(imm), .id_target(jump_target),
		.id_pc4(id_pc4), .id_rdata1(rdata1), .id_rdata2(rdata2),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read), .br_taken(br_taken), .br_target(br_target),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read),
		.mem_mem_write(mem_mem_write), .mem_to_reg(mem_to_reg_q), .mem_link(mem_link),
		.mem_alu(mem_alu), .mem_store(mem_store), .mem_pc4(mem_pc4)
	);

	mem_wb_stage u_mem_wb (
		.clk(clk), .rst_n(rst_n), .freeze(freeze),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read),
		.mem_mem_write(mem_mem_write), .mem_to_reg(mem_to_reg_q), .mem_link(mem_link),
		.mem_alu(mem_alu), .mem_store(mem_store), .mem_pc4(mem_pc4), .dmem_rdata(dmem_rdata),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

// ==== tests/core_asserts.sv ====
// bound into riscv_core; checks port protocol only, not data values
`timescale 1ns/1ps

module core_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      imem_stall,
	input logic                      dmem_stall,
	input logic                      dmem_read,
	input logic                      dmem_write,
	input logic [pipe_pkg::pc_w-3:0] imem_addr,
	input logic [pipe_pkg::xlen-3:0] dmem_addr,
	input logic [pipe_pkg::xlen-1:0] dmem_wdata
);
	int fail_count = 0;
	logic freeze;

	assign freeze = imem_stall | dmem_stall;

	// ----------------------------------------------------------------------
	// every port output holds across a stalled cycle
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		freeze |=> $stable(imem_addr) && $stable(dmem_addr) && $stable(dmem_wdata)
			&& $stable(dmem_read) && $stable(dmem_write))
	else begin
		$error("port outputs changed on the cycle after a memory stall");
		fail_count++;
	end

	// strobes come out of reset low
	quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !dmem_read && !dmem_write)
	else begin
		$error("data strobe high in the first cycle after reset");
		fail_count++;
	end

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_read && dmem_write))
	else begin
		$error("dmem_read and dmem_write high together");
		fail_count++;
	end

endmodule

// ==== tests/tb_core.sv ====
// stalls come from a fixed-seed LFSR; a store counts only on the edge where the whole pipe moves
`timescale 1ns/1ps

module tb_core;

	localparam int prog_words = 40;
	// worst case of about 100 cycles per instruction under random stalls
	localparam int watchdog_cycles = prog_words * 100;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic imem_stall = 1'b0;
	logic dmem_stall = 1'b0;
	logic [pipe_pkg::pc_w-3:0] imem_addr;
	logic [pipe_pkg::xlen-1:0] imem_rdata;
	logic [pipe_pkg::xlen-1:0] dmem_rdata;
	logic [pipe_pkg::xlen-1:0] dmem_wdata;
	logic [pipe_pkg::xlen-3:0] dmem_addr;
	logic dmem_read;
	logic dmem_write;

	logic [31:0] imem [128];
	logic [31:0] dmem [128];
	logic [15:0] lfsr = 16'd54952;
	int n_words = 0;
	int n_seen = 0;
	int errors = 0;
	string exp_name[$];
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];

	riscv_core dut0 (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.imem_stall(imem_stall), .dmem_read(dmem_read), .dmem_write(dmem_write),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
		.dmem_stall(dmem_stall)
	);

	bind riscv_core core_asserts u_asserts (
		.clk(clk), .rst_n(rst_n), .imem_stall(imem_stall), .dmem_stall(dmem_stall),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .imem_addr(imem_addr),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
	);

	always #5 clk = ~clk;

	assign imem_rdata = imem[imem_addr];
	// data only comes back for a read request
	assign dmem_rdata = dmem_read ? dmem[dmem_addr[6:0]] : 32'hdead_beef;

	// ----------------------------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic next_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b = lfsr[0];
	endtask

	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [31:0] rd, rs1, rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], isa_pkg::op_rtype};
	endfunction

	function automatic logic [31:0] itype_word(input logic [6:0] op, input logic [2:0] f3,
		input logic [31:0] rd, rs1, imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] store_word(input logic [31:0] rs2, rs1, imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], isa_pkg::op_store};
	endfunction

	function automatic logic [31:0] branch_word(input logic [2:0] f3,
		input logic [31:0] rs1, rs2, imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
			isa_pkg::op_branch};
	endfunction

	function automatic logic [31:0] jal_word(input logic [31:0] rd, imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], isa_pkg::op_jal};
	endfunction

	task automatic put(input logic [31:0] w);
		imem[n_words] = w;
		n_words++;
	endtask

	task automatic expect_store(input string name, input int word, input int data);
		exp_name.push_back(name);
		exp_addr.push_back(word);
		exp_data.push_back(data);
	endtask

	task automatic check_value(input string test, input logic [31:0] expected, actual);
		assert (actual === expected)
		else begin
			$display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
			errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	task automatic load_program;
		put(itype_word(isa_pkg::op_itype, 3'b000, 1, 0, 5));
		put(itype_word(isa_pkg::op_itype, 3'b000, 2, 0, -3));
		put(rtype_word(7'b0, 3'b000, 3, 1, 2));
		put(rtype_word(isa_pkg::f7_sub, 3'b000, 4, 3, 1));
		put(rtype_word(7'b0, isa_pkg::f3_and, 5, 4, 1));
		put(rtype_word(7'b0, isa_pkg::f3_or, 6, 5, 2));
		put(rtype_word(7'b0, isa_pkg::f3_slt, 7, 2, 1));
		put(itype_word(isa_pkg::op_itype, isa_pkg::f3_slt, 8, 4, -4));
		put(itype_word(isa_pkg::op_itype, isa_pkg::f3_and, 10, 6, 15));
		put(store_word(10, 0, 20));
		put(store_word(3, 0, 0));
		put(store_word(4, 0, 4));
		put(store_word(6, 0, 8));
		put(store_word(7, 0, 12));
		put(store_word(8, 0, 16));
		// load-use pair at 17 and 18
		put(itype_word(isa_pkg::op_itype, isa_pkg::f3_or, 9, 3, 'h30));
		put(store_word(9, 0, 24));
		put(itype_word(isa_pkg::op_load, 3'b010, 11, 0, 24));
		put(rtype_word(7'b0, 3'b000, 12, 11, 1));
		put(store_word(12, 0, 28));
		// branches, shadow stores go to word 25 and 26
		put(branch_word(3'b000, 1, 2, 12));
		put(itype_word(isa_pkg::op_itype, 3'b000, 13, 0, 1));
		put(branch_word(3'b000, 3, 3, 12));
		put(store_word(1, 0, 100));
		put(store_word(2, 0, 104));
		put(branch_word(isa_pkg::f3_bne, 1, 2, 12));
		put(store_word(1, 0, 100));
		put(store_word(2, 0, 104));
		put(branch_word(isa_pkg::f3_bne, 1, 1, 8));
		put(itype_word(isa_pkg::op_itype, 3'b000, 13, 13, 2));
		put(store_word(13, 0, 32));
		// jal at 31 skips 32; jalr at 35 lands on 38
		put(jal_word(14, 8));
		put(store_word(1, 0, 100));
		put(store_word(14, 0, 36));
		put(itype_word(isa_pkg::op_itype, 3'b000, 15, 0, 38 * 4));
		put(itype_word(isa_pkg::op_jalr, 3'b000, 16, 15, 0));
		put(store_word(1, 0, 100));
		put(store_word(2, 0, 104));
		put(store_word(16, 0, 40));
		put(jal_word(0, 0));
	endtask

	task automatic build_expected;
		int r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r12, r13;
		r1 = 5;
		r2 = -3;
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = r4 & r1;
		r6 = r5 | r2;
		r7 = (r2 < r1) ? 1 : 0;
		r8 = (r4 < -4) ? 1 : 0;
		r10 = r6 & 15;
		r9 = r3 | 'h30;
		r12 = r9 + r1;
		r13 = 1 + 2;
		expect_store("andi to store data", 5, r10);
		expect_store("add", 0, r3);
		expect_store("sub", 1, r4);
		expect_store("and or chain", 2, r6);
		expect_store("slt", 3, r7);
		expect_store("slti", 4, r8);
		expect_store("ori before load", 6, r9);
		expect_store("load use add", 7, r12);
		expect_store("branch fall through", 8, r13);
		expect_store("jal link", 9, (31 + 1) * 4);
		expect_store("jalr link", 10, (35 + 1) * 4);
	endtask

	// ----------------------------------------------------------------------
	always @(posedge clk) begin : stall_drive
		logic b0, b1, b2, b3;
		next_bit(b0);
		next_bit(b1);
		next_bit(b2);
		next_bit(b3);
		imem_stall <= b0 & b1;
		dmem_stall <= b2 & b3;
	end

	always @(posedge clk) begin
		if (rst_n && dmem_write && !imem_stall && !dmem_stall) begin
			if (n_seen < exp_addr.size()) begin
				check_value({exp_name[n_seen], " address"}, exp_addr[n_seen], {2'b00, dmem_addr});
				check_value({exp_name[n_seen], " data"}, exp_data[n_seen], dmem_wdata);
			end else begin
				$display("unexpected store to word %0d after the last expected one", dmem_addr);
				errors++;
			end
			n_seen++;
			dmem[dmem_addr[6:0]] <= dmem_wdata;
		end
	end

	initial begin
		int asserts_failed;
		// no-op addi tagged with its own address
		for (int i = 0; i < 128; i++) begin
			imem[i[6:0]] = itype_word(isa_pkg::op_itype, 3'b000, 0, 0, i);
			dmem[i[6:0]] <= 32'hd00d_0000 | i;
		end
		load_program();
		build_expected();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		while (n_seen < exp_addr.size())
			@(posedge clk);
		// a few more cycles to catch a stray store
		repeat (10) @(posedge clk);
		asserts_failed = dut0.u_asserts.fail_count;
		$display("closing count: %0d store errors, %0d assertion failures, %0d stores seen",
			errors, asserts_failed, n_seen);
		if (errors == 0 && asserts_failed == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("timeout: only %0d of %0d stores after %0d cycles, the core seems hung",
			n_seen, exp_addr.size(), watchdog_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
logic/pipe_pkg.sv
logic/isa_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_ctrl.sv
logic/hazard_forward.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/riscv_core.sv
tests/core_asserts.sv
tests/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f files.f -o sim_core &&
./obj_dir/sim_core +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || grep -q "ALL CHECKS PASSED" sim.log
